/* hdl/des_key_pkg.sv */
`default_nettype none

package des_key_pkg;

    // widths fixed by the DES standard
    localparam int MAIN_KEY_W  = 64;  // includes the eight parity bits
    localparam int HALF_W      = 28;  // one of C or D
    localparam int ROUND_KEY_W = 48;
    localparam int NUM_ROUNDS  = 16;

    typedef logic [MAIN_KEY_W-1:0] main_key_t;

    // 56-bit key after PC-1, split into the halves that rotate independently
    typedef struct packed {
        logic [HALF_W-1:0] c;  // upper half
        logic [HALF_W-1:0] d;  // lower half
    } cd_key_t;

    typedef logic [ROUND_KEY_W-1:0] round_key_t;

    typedef logic [$clog2(NUM_ROUNDS)-1:0] round_idx_t;

    typedef enum logic {
        MODE_ENCRYPT = 1'b0,
        MODE_DECRYPT = 1'b1
    } key_mode_t;

    // encrypt shift schedule, bit r set means round r rotates by two
    // rounds 0, 1, 8 and 15 rotate by one, all others by two
    // the amounts add up to 28, so C and D return to the PC-1 value after round 15
    localparam logic [NUM_ROUNDS-1:0] SHIFT_TWO = 16'h7EFC;

endpackage

`default_nettype wire

/* hdl/pc1_permute.sv */
`timescale 1ns/1ps
`default_nettype none

// permuted choice 1
// bit numbering follows main_key[63:0], parity bits at 0, 8, ..., 56 are never selected
module pc1_permute
    import des_key_pkg::*;
(
    input  main_key_t main_key,
    output cd_key_t   pc1_key
);

    // C half, pc1_key.c[27] first
    assign pc1_key.c = {
        main_key[7],  main_key[15], main_key[23], main_key[31],
        main_key[39], main_key[47], main_key[55], main_key[63],
        main_key[6],  main_key[14], main_key[22], main_key[30],
        main_key[38], main_key[46], main_key[54], main_key[62],
        main_key[5],  main_key[13], main_key[21], main_key[29],
        main_key[37], main_key[45], main_key[53], main_key[61],
        main_key[4],  main_key[12], main_key[20], main_key[28]
    };

    // D half, pc1_key.d[27] first
    // the last four come from the column that C leaves behind
    assign pc1_key.d = {
        main_key[1],  main_key[9],  main_key[17], main_key[25],
        main_key[33], main_key[41], main_key[49], main_key[57],
        main_key[2],  main_key[10], main_key[18], main_key[26],
        main_key[34], main_key[42], main_key[50], main_key[58],
        main_key[3],  main_key[11], main_key[19], main_key[27],
        main_key[35], main_key[43], main_key[51], main_key[59],
        main_key[36], main_key[44], main_key[52], main_key[60]
    };

endmodule

`default_nettype wire

/* hdl/key_rotator.sv */
`timescale 1ns/1ps
`default_nettype none

// round counter and C/D storage
// encrypt rotates left along the schedule, decrypt walks it backwards rotating right
module key_rotator
    import des_key_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       enable,
    input  logic       next_key,
    input  key_mode_t  mode,
    input  cd_key_t    pc1_key,
    output cd_key_t    cd_reg,
    output cd_key_t    cd_rotated,
    output round_idx_t round_idx
);

    cd_key_t    cd_src;      // halves entering the rotator this round
    round_idx_t rev_idx;     // position in the schedule seen from the end
    logic       last_round;
    logic       shift_two;   // rotate by 2 instead of 1

    // circular rotate of one half by 1 or 2 bits in either direction
    function automatic logic [HALF_W-1:0] rotate_half(
        input logic [HALF_W-1:0] half,
        input key_mode_t         dir,
        input logic              by_two
    );
        logic [HALF_W-1:0] result;
        if (dir == MODE_ENCRYPT) begin
            if (by_two)
                result = {half[HALF_W-3:0], half[HALF_W-1:HALF_W-2]};
            else
                result = {half[HALF_W-2:0], half[HALF_W-1]};
        end else begin
            if (by_two)
                result = {half[1:0], half[HALF_W-1:2]};
            else
                result = {half[0], half[HALF_W-1:1]};
        end
        return result;
    endfunction

    assign last_round = (round_idx == round_idx_t'(NUM_ROUNDS - 1));
    assign rev_idx    = round_idx_t'(NUM_ROUNDS - 1) - round_idx;

    // round 0 starts from the fresh PC-1 key, later rounds from the register
    assign cd_src = (round_idx == '0) ? pc1_key : cd_reg;

    always_comb begin
        if (mode == MODE_ENCRYPT)
            shift_two = SHIFT_TWO[round_idx];
        else
            shift_two = SHIFT_TWO[rev_idx] | last_round;  // decrypt round 15 wraps, amount unused
    end

    assign cd_rotated.c = rotate_half(cd_src.c, mode, shift_two);
    assign cd_rotated.d = rotate_half(cd_src.d, mode, shift_two);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            round_idx <= '0;
            cd_reg    <= '0;
        end else if (enable && next_key) begin
            if (last_round) begin
                // sequence done, next round 0 takes pc1_key again
                round_idx <= '0;
                cd_reg    <= '0;
            end else begin
                round_idx <= round_idx + round_idx_t'(1);
                cd_reg    <= cd_rotated;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/pc2_select_permute.sv */
`timescale 1ns/1ps
`default_nettype none

// picks the 56-bit word for this round and applies permuted choice 2
module pc2_select_permute
    import des_key_pkg::*;
(
    input  key_mode_t  mode,
    input  round_idx_t round_idx,
    input  cd_key_t    pc1_key,
    input  cd_key_t    cd_reg,
    input  cd_key_t    cd_rotated,
    output round_key_t key_out
);

    cd_key_t pc2_src;

    // encrypt shows the halves after this round's shift
    // decrypt round 0 is encrypt round 15, which equals the unshifted PC-1 key
    always_comb begin
        if (mode == MODE_ENCRYPT)
            pc2_src = cd_rotated;
        else if (round_idx == '0)
            pc2_src = pc1_key;
        else
            pc2_src = cd_reg;  // already shifted back by the previous load
    end

    // PC-2, key_out[47] first
    // bits 2, 13, 18, 21, 31, 34, 38 and 47 of the 56-bit word are dropped
    assign key_out = {
        pc2_src[42], pc2_src[39], pc2_src[45], pc2_src[32],
        pc2_src[55], pc2_src[51], pc2_src[53], pc2_src[28],
        pc2_src[41], pc2_src[50], pc2_src[35], pc2_src[46],
        pc2_src[33], pc2_src[37], pc2_src[44], pc2_src[52],
        pc2_src[30], pc2_src[48], pc2_src[40], pc2_src[49],
        pc2_src[29], pc2_src[36], pc2_src[43], pc2_src[54],  // upper 24 from C
        pc2_src[15], pc2_src[4],  pc2_src[25], pc2_src[19],
        pc2_src[9],  pc2_src[1],  pc2_src[26], pc2_src[16],
        pc2_src[5],  pc2_src[11], pc2_src[23], pc2_src[8],
        pc2_src[12], pc2_src[7],  pc2_src[17], pc2_src[0],
        pc2_src[22], pc2_src[3],  pc2_src[10], pc2_src[14],
        pc2_src[6],  pc2_src[20], pc2_src[27], pc2_src[24]   // lower 24 from D
    };

endmodule

`default_nettype wire

/* hdl/des_key_schedule.sv */
`timescale 1ns/1ps
`default_nettype none

// DES key schedule, one 48-bit round key per next_key pulse
// key_out is combinational from main_key, mode and the stored round state
module des_key_schedule
    import des_key_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       enable,
    input  logic       next_key,
    input  key_mode_t  mode,       // hold steady for a whole sequence
    input  main_key_t  main_key,   // hold steady for a whole sequence
    output round_key_t key_out
);

    cd_key_t    pc1_key;
    cd_key_t    cd_reg;
    cd_key_t    cd_rotated;
    round_idx_t round_idx;

    pc1_permute u_pc1 (
        .main_key (main_key),
        .pc1_key  (pc1_key)
    );

    key_rotator u_rotator (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .next_key   (next_key),
        .mode       (mode),
        .pc1_key    (pc1_key),
        .cd_reg     (cd_reg),
        .cd_rotated (cd_rotated),
        .round_idx  (round_idx)
    );

    pc2_select_permute u_pc2 (
        .mode       (mode),
        .round_idx  (round_idx),
        .pc1_key    (pc1_key),
        .cd_reg     (cd_reg),
        .cd_rotated (cd_rotated),
        .key_out    (key_out)
    );

endmodule

`default_nettype wire

/* verif/key_checker.sv */
`timescale 1ns/1ps
`default_nettype none

// watches the DUT ports, keeps its own round count and compares key_out every cycle
module key_checker
    import des_key_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       enable,
    input  logic       next_key,
    input  key_mode_t  mode,
    input  main_key_t  main_key,
    input  round_key_t key_out,
    output int         check_count,
    output int         error_count
);

    localparam int        NUM_ROWS    = 64;             // four main keys, sixteen rounds each
    localparam int        NUM_WORDS   = 3 * NUM_ROWS;   // key, round, expected key per row
    localparam main_key_t PARITY_BITS = 64'h0101_0101_0101_0101;

    logic [63:0] case_words [0:NUM_WORDS-1];
    round_idx_t  exp_round;     // round the DUT should be showing
    int          checks = 0;
    int          errors = 0;

    initial begin
        $readmemh("verif/key_cases.txt", case_words);
    end

    assign check_count = checks;
    assign error_count = errors;

    // row of the table for this main key and encrypt round, -1 if none
    // parity bits take no part in the match
    function automatic int find_row(input main_key_t key, input int round);
        int row;
        int i;
        row = -1;
        for (i = 0; i < NUM_ROWS; i++) begin
            if (((case_words[3*i] & ~PARITY_BITS) == (key & ~PARITY_BITS)) &&
                (case_words[3*i+1] == 64'(round)))
                row = i;
        end
        return row;
    endfunction

    // one step per next_key seen with enable high, back to 0 after round 15
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exp_round <= '0;
        end else if (enable && next_key) begin
            if (exp_round == round_idx_t'(NUM_ROUNDS - 1))
                exp_round <= '0;
            else
                exp_round <= exp_round + round_idx_t'(1);
        end
    end

    // inputs move on the rising edge, so the falling edge sees settled values
    always @(negedge clk) begin
        int         row;
        int         table_round;
        round_key_t expected;
        if (mode == MODE_DECRYPT)
            table_round = NUM_ROUNDS - 1 - int'(exp_round);  // decrypt walks the table backwards
        else
            table_round = int'(exp_round);
        row = find_row(main_key, table_round);
        checks = checks + 1;
        if (row < 0) begin
            errors = errors + 1;
            $display("checker found no table entry for main key %h at round %0d",
                     main_key, table_round);
        end else begin
            expected = case_words[3*row+2][ROUND_KEY_W-1:0];
            if (key_out !== expected) begin
                errors = errors + 1;
                $display("** Error at %0t ns: key_out %h, expected %h (mode %0d, round %0d)",
                         $time, key_out, expected, mode, exp_round);
            end
        end
    end

endmodule

`default_nettype wire

/* verif/tb_des_key_schedule.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_des_key_schedule
    import des_key_pkg::*;
();

    localparam int        NUM_KEYS         = 4;
    localparam int        NUM_WORDS        = 3 * NUM_KEYS * NUM_ROUNDS;
    localparam int        RESET_CYCLES     = 16;
    localparam int        MID_RESET_ROUNDS = 5;
    localparam int        CYCLES_PER_ROUND = 40;
    // four sequences per key, a cut-short one before the second reset, a full one after it
    localparam int        ROUNDS_TESTED    = NUM_KEYS * 4 * NUM_ROUNDS + MID_RESET_ROUNDS
                                             + NUM_ROUNDS;
    localparam int        TIMEOUT_CYCLES   = ROUNDS_TESTED * CYCLES_PER_ROUND + 2 * RESET_CYCLES;
    localparam main_key_t PARITY_BITS      = 64'h0101_0101_0101_0101;

    logic       clk;
    logic       rst;
    logic       enable;
    logic       next_key;
    key_mode_t  mode;
    main_key_t  main_key;
    round_key_t key_out;

    logic [63:0] case_words [0:NUM_WORDS-1];  // same table the checker uses
    int          checks;
    int          errors;
    int          setup_errors = 0;
    int          cycle_count  = 0;

    des_key_schedule DUT (
        .clk      (clk),
        .rst      (rst),
        .enable   (enable),
        .next_key (next_key),
        .mode     (mode),
        .main_key (main_key),
        .key_out  (key_out)
    );

    key_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .next_key    (next_key),
        .mode        (mode),
        .main_key    (main_key),
        .key_out     (key_out),
        .check_count (checks),
        .error_count (errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("timeout after %0d cycles, the stimulus did not finish", cycle_count);
        $display("Result: FAILED");
        $finish;
    end

    task automatic apply_reset();
        @(posedge clk);
        rst      <= 1'b1;
        next_key <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    endtask

    // random idle gap, sometimes an enable-low stretch with stray pulses, then one real pulse
    task automatic advance_round();
        int gap;
        int hold;
        gap = $urandom_range(0, 3);
        repeat (gap) @(posedge clk);
        if ($urandom_range(0, 3) == 0) begin
            hold = $urandom_range(1, 4);
            repeat (hold) begin
                @(posedge clk);
                enable   <= 1'b0;
                next_key <= ($urandom_range(0, 1) == 1);  // must be ignored
            end
            @(posedge clk);
            enable   <= 1'b1;
            next_key <= 1'b0;
        end
        @(posedge clk);
        next_key <= 1'b1;
        @(posedge clk);
        next_key <= 1'b0;
    endtask

    // key and mode only change while the DUT sits at round 0
    task automatic run_sequence(input main_key_t key, input key_mode_t seq_mode, input int rounds);
        int r;
        @(posedge clk);
        main_key <= key;
        mode     <= seq_mode;
        enable   <= 1'b1;
        next_key <= 1'b0;
        for (r = 0; r < rounds; r++)
            advance_round();
    endtask

    initial begin
        int        k;
        int        total_errors;
        main_key_t key;
        rst      <= 1'b1;
        enable   <= 1'b0;
        next_key <= 1'b0;
        mode     <= MODE_ENCRYPT;
        main_key <= '0;
        void'($urandom(16));
        $readmemh("verif/key_cases.txt", case_words);
        // the last row must carry round 15 in its round column
        if ($isunknown(case_words[0]) || $isunknown(case_words[NUM_WORDS-1]) ||
            (case_words[NUM_WORDS-2] != 64'(NUM_ROUNDS - 1))) begin
            $display("the case file verif/key_cases.txt could not be read completely");
            setup_errors = setup_errors + 1;
        end
        apply_reset();
        for (k = 0; k < NUM_KEYS; k++) begin
            key = case_words[3 * NUM_ROUNDS * k];
            run_sequence(key, MODE_ENCRYPT, NUM_ROUNDS);
            run_sequence(key, MODE_DECRYPT, NUM_ROUNDS);
            run_sequence(key ^ PARITY_BITS, MODE_ENCRYPT, NUM_ROUNDS);  // parity bits flipped
            run_sequence(key ^ PARITY_BITS, MODE_DECRYPT, NUM_ROUNDS);
        end
        // reset in the middle of a sequence, then a clean run
        key = case_words[0];
        run_sequence(key, MODE_DECRYPT, MID_RESET_ROUNDS);
        apply_reset();
        run_sequence(key, MODE_ENCRYPT, NUM_ROUNDS);
        repeat (2) @(posedge clk);
        if (checks == 0) begin
            $display("the checker made no comparisons");
            setup_errors = setup_errors + 1;
        end
        total_errors = errors + setup_errors;
        $display("checks: %0d, errors: %0d", checks, total_errors);
        if (total_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/key_cases.txt */
// columns: main key, round index, expected encrypt round key (all hex)
// one line per main key and round, rounds 0 to 15 in order
133457799bbcdff1 0 1b02effc7072
133457799bbcdff1 1 79aed9dbc9e5
133457799bbcdff1 2 55fc8a42cf99
133457799bbcdff1 3 72add6db351d
133457799bbcdff1 4 7cec07eb53a8
133457799bbcdff1 5 63a53e507b2f
133457799bbcdff1 6 ec84b7f618bc
133457799bbcdff1 7 f78a3ac13bfb
133457799bbcdff1 8 e0dbebede781
133457799bbcdff1 9 b1f347ba464f
133457799bbcdff1 a 215fd3ded386
133457799bbcdff1 b 7571f59467e9
133457799bbcdff1 c 97c5d1faba41
133457799bbcdff1 d 5f43b7f2e73a
133457799bbcdff1 e bf918d3d3f0a
133457799bbcdff1 f cb3d8b0e17f5
0000000000000000 0 000000000000
0000000000000000 1 000000000000
0000000000000000 2 000000000000
0000000000000000 3 000000000000
0000000000000000 4 000000000000
0000000000000000 5 000000000000
0000000000000000 6 000000000000
0000000000000000 7 000000000000
0000000000000000 8 000000000000
0000000000000000 9 000000000000
0000000000000000 a 000000000000
0000000000000000 b 000000000000
0000000000000000 c 000000000000
0000000000000000 d 000000000000
0000000000000000 e 000000000000
0000000000000000 f 000000000000
1f1f1f1f0e0e0e0e 0 000000ffffff
1f1f1f1f0e0e0e0e 1 000000ffffff
1f1f1f1f0e0e0e0e 2 000000ffffff
1f1f1f1f0e0e0e0e 3 000000ffffff
1f1f1f1f0e0e0e0e 4 000000ffffff
1f1f1f1f0e0e0e0e 5 000000ffffff
1f1f1f1f0e0e0e0e 6 000000ffffff
1f1f1f1f0e0e0e0e 7 000000ffffff
1f1f1f1f0e0e0e0e 8 000000ffffff
1f1f1f1f0e0e0e0e 9 000000ffffff
1f1f1f1f0e0e0e0e a 000000ffffff
1f1f1f1f0e0e0e0e b 000000ffffff
1f1f1f1f0e0e0e0e c 000000ffffff
1f1f1f1f0e0e0e0e d 000000ffffff
1f1f1f1f0e0e0e0e e 000000ffffff
1f1f1f1f0e0e0e0e f 000000ffffff
e0e0e0e0f1f1f1f1 0 ffffff000000
e0e0e0e0f1f1f1f1 1 ffffff000000
e0e0e0e0f1f1f1f1 2 ffffff000000
e0e0e0e0f1f1f1f1 3 ffffff000000
e0e0e0e0f1f1f1f1 4 ffffff000000
e0e0e0e0f1f1f1f1 5 ffffff000000
e0e0e0e0f1f1f1f1 6 ffffff000000
e0e0e0e0f1f1f1f1 7 ffffff000000
e0e0e0e0f1f1f1f1 8 ffffff000000
e0e0e0e0f1f1f1f1 9 ffffff000000
e0e0e0e0f1f1f1f1 a ffffff000000
e0e0e0e0f1f1f1f1 b ffffff000000
e0e0e0e0f1f1f1f1 c ffffff000000
e0e0e0e0f1f1f1f1 d ffffff000000
e0e0e0e0f1f1f1f1 e ffffff000000
e0e0e0e0f1f1f1f1 f ffffff000000

/* sim.f */
hdl/des_key_pkg.sv
hdl/pc1_permute.sv
hdl/key_rotator.sv
hdl/pc2_select_permute.sv
hdl/des_key_schedule.sv
verif/key_checker.sv
verif/tb_des_key_schedule.sv

/* run_sim.sh */
#!/bin/sh
# build and run the DES key schedule testbench, run from the project root
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module tb_des_key_schedule \
    -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log \
    && { echo "testbench reported a failure"; exit 1; } \
    || { echo "no failure found in sim.log"; exit 0; }
